/* hw/cursor_pkg.sv */
package cursor_pkg;

  // frame geometry.
  localparam int unsigned FRAME_DIM = 64;

  typedef logic [$clog2(FRAME_DIM)-1:0] coord_t;
  typedef logic [7:0]                   pixel_t;

  // position after reset, centre of the frame.
  localparam coord_t CURSOR_HOME_X = coord_t'(32);
  localparam coord_t CURSOR_HOME_Y = coord_t'(32);

  // cursor colours.
  localparam pixel_t PIXEL_WHITE = 8'hff;
  localparam pixel_t PIXEL_BLACK = 8'h00;

  // hold interval lengths in clock cycles.
  localparam int unsigned WHITE_CYCLES = 8;
  localparam int unsigned BLACK_CYCLES = 5;

  // one blink takes WHITE_CYCLES + BLACK_CYCLES + 4 cycles.
  typedef enum logic [2:0] {
    idle        = 3'b000,
    paint_white = 3'b001,
    hold_white  = 3'b010,
    paint_black = 3'b011,
    hold_black  = 3'b100,
    done        = 3'b101
  } blink_state_t;

endpackage

/* hw/pixel_write_if.sv */
`timescale 1ns/100ps

interface pixel_write_if import cursor_pkg::*; ();

  logic   we;   // one write per cycle while high.
  coord_t x;
  coord_t y;
  pixel_t data;

  modport source (
    output we,
    output x,
    output y,
    output data
  );

  modport sink (
    input we,
    input x,
    input y,
    input data
  );

endinterface

/* hw/cursor_move.sv */
`timescale 1ns/100ps

module cursor_move import cursor_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   step_left,
  input  logic   step_right,
  input  logic   step_up,
  input  logic   step_down,
  output coord_t cursor_x,
  output coord_t cursor_y
);

  coord_t pos_x;
  coord_t pos_y;
  coord_t next_x;
  coord_t next_y;

  // one step along an axis, wrapping at both frame edges.
  function automatic coord_t step_axis(
    input coord_t pos,
    input logic   dec,
    input logic   inc
  );
    coord_t result;
    result = pos;
    if (inc && !dec) begin
      if (pos == coord_t'(FRAME_DIM - 1)) begin
        result = '0;
      end else begin
        result = pos + 1'b1;
      end
    end else if (dec && !inc) begin
      if (pos == '0) begin
        result = coord_t'(FRAME_DIM - 1);
      end else begin
        result = pos - 1'b1;
      end
    end
    return result; // opposite pulses cancel.
  endfunction

  always_comb begin
    next_x = step_axis(pos_x, step_left, step_right);
    next_y = step_axis(pos_y, step_up, step_down); // y grows downwards.
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pos_x <= CURSOR_HOME_X;
      pos_y <= CURSOR_HOME_Y;
    end else begin
      pos_x <= next_x;
      pos_y <= next_y;
    end
  end

  assign cursor_x = pos_x;
  assign cursor_y = pos_y;

endmodule

/* hw/blink_timer.sv */
`timescale 1ns/100ps

module blink_timer #(
  parameter int unsigned LENGTH = 4
) (
  input  logic clk,
  input  logic rst,
  input  logic run,
  output logic last
);

  // wide enough to hold LENGTH - 1, at least one bit.
  typedef logic [$clog2(LENGTH + 1)-1:0] cnt_t;

  cnt_t count;

  // index of the current run cycle, starting at zero.
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (!run) begin
      count <= '0; // self clear between intervals.
    end else if (last) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // high in run cycle LENGTH - 1.
  assign last = run && (count == cnt_t'(LENGTH - 1));

endmodule

/* hw/cursor_blink_ctrl.sv */
`timescale 1ns/100ps

module cursor_blink_ctrl import cursor_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          blink,
  input  coord_t        cursor_x,
  input  coord_t        cursor_y,
  input  logic          white_last,
  input  logic          black_last,
  output logic          white_run,
  output logic          black_run,
  pixel_write_if.source wr,
  output logic          blink_done
);

  blink_state_t state;
  blink_state_t next_state;

  coord_t lat_x;
  coord_t lat_y;

  always_comb begin
    next_state = state;
    unique case (state)
      idle: begin
        if (blink) begin
          next_state = paint_white;
        end
      end
      paint_white: next_state = hold_white;
      hold_white: begin
        if (white_last) begin
          next_state = paint_black;
        end
      end
      paint_black: next_state = hold_black;
      hold_black: begin
        if (black_last) begin
          next_state = done;
        end
      end
      done: next_state = idle;
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  // position is frozen once a blink starts.
  always_ff @(posedge clk) begin
    if (state == idle) begin
      lat_x <= cursor_x;
      lat_y <= cursor_y;
    end
  end

  always_comb begin
    wr.we      = 1'b0;
    wr.data    = PIXEL_BLACK;
    white_run  = 1'b0;
    black_run  = 1'b0;
    blink_done = 1'b0;
    unique case (state)
      paint_white: begin
        wr.we   = 1'b1;
        wr.data = PIXEL_WHITE;
      end
      hold_white:  white_run = 1'b1;
      paint_black: wr.we = 1'b1;
      hold_black:  black_run = 1'b1;
      done:        blink_done = 1'b1;
      default: begin
        wr.we = 1'b0; // idle.
      end
    endcase
  end

  assign wr.x = lat_x;
  assign wr.y = lat_y;

endmodule

/* hw/frame_buffer.sv */
`timescale 1ns/100ps

module frame_buffer import cursor_pkg::*; (
  input  logic        clk,
  pixel_write_if.sink wr,
  input  coord_t      scan_x,
  input  coord_t      scan_y,
  output pixel_t      scan_pixel
);

  // row major, address is {y, x}.
  pixel_t mem [FRAME_DIM * FRAME_DIM];

  logic [2*$bits(coord_t)-1:0] wr_addr;
  logic [2*$bits(coord_t)-1:0] rd_addr;

  assign wr_addr = {wr.y, wr.x};
  assign rd_addr = {scan_y, scan_x};

  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr_addr] <= wr.data;
    end
  end

  // registered read, old data on a same-cycle write.
  always_ff @(posedge clk) begin
    scan_pixel <= mem[rd_addr];
  end

endmodule

/* hw/cursor_display_top.sv */
`timescale 1ns/100ps

module cursor_display_top import cursor_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  logic   step_left,
  input  logic   step_right,
  input  logic   step_up,
  input  logic   step_down,
  input  logic   blink,
  input  coord_t scan_x,
  input  coord_t scan_y,
  output coord_t cursor_x,
  output coord_t cursor_y,
  output pixel_t scan_pixel,
  output logic   blink_done
);

  logic white_run;
  logic black_run;
  logic white_last;
  logic black_last;

  pixel_write_if pixel_wr ();

  cursor_move cursor_move_i (
    .clk        (clk),
    .rst        (rst),
    .step_left  (step_left),
    .step_right (step_right),
    .step_up    (step_up),
    .step_down  (step_down),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y)
  );

  blink_timer #(
    .LENGTH (WHITE_CYCLES)
  ) white_timer_i (
    .clk  (clk),
    .rst  (rst),
    .run  (white_run),
    .last (white_last)
  );

  blink_timer #(
    .LENGTH (BLACK_CYCLES)
  ) black_timer_i (
    .clk  (clk),
    .rst  (rst),
    .run  (black_run),
    .last (black_last)
  );

  cursor_blink_ctrl cursor_blink_ctrl_i (
    .clk        (clk),
    .rst        (rst),
    .blink      (blink),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y),
    .white_last (white_last),
    .black_last (black_last),
    .white_run  (white_run),
    .black_run  (black_run),
    .wr         (pixel_wr.source),
    .blink_done (blink_done)
  );

  frame_buffer frame_buffer_i (
    .clk        (clk),
    .wr         (pixel_wr.sink),
    .scan_x     (scan_x),
    .scan_y     (scan_y),
    .scan_pixel (scan_pixel)
  );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  localparam int RESET_CYCLES = 5;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* sim/cursor_display_tb.sv */
`timescale 1ns/100ps

module cursor_display_tb import cursor_pkg::*; ();

  localparam int EDGE_STEPS   = 33;  // enough to cross one frame edge from home.
  localparam int RANDOM_STEPS = 200;
  localparam int NUM_BLINKS   = 6;
  localparam int MOVE_CYCLES  = 4 * EDGE_STEPS + RANDOM_STEPS;
  localparam int BLINK_PERIOD = WHITE_CYCLES + BLACK_CYCLES + 4;
  localparam int BLACK_OFFSET = WHITE_CYCLES + 1; // black write, cycles after white write.
  localparam int DONE_OFFSET  = WHITE_CYCLES + BLACK_CYCLES + 2;
  localparam int TIMEOUT_CYCLES = NUM_BLINKS * BLINK_PERIOD + MOVE_CYCLES + 200;

  // step bit order is {left, right, up, down}.
  localparam logic [3:0] STEP_NONE  = 4'b0000;
  localparam logic [3:0] STEP_LEFT  = 4'b1000;
  localparam logic [3:0] STEP_RIGHT = 4'b0100;
  localparam logic [3:0] STEP_UP    = 4'b0010;
  localparam logic [3:0] STEP_DOWN  = 4'b0001;

  logic   clk;
  logic   rst;
  logic   step_left;
  logic   step_right;
  logic   step_up;
  logic   step_down;
  logic   blink;
  coord_t scan_x;
  coord_t scan_y;
  coord_t cursor_x;
  coord_t cursor_y;
  pixel_t scan_pixel;
  logic   blink_done;

  int cyc = 0;
  int seed = 27;
  int coord_errors = 0;
  int pixel_errors = 0;
  int flag_errors = 0;
  int other_errors = 0;
  int white_checks = 0;
  int black_checks = 0;
  int last_done = -1;

  // position model and the record of painted blinks.
  coord_t model_x = CURSOR_HOME_X;
  coord_t model_y = CURSOR_HOME_Y;
  int     cur_start = -1; // paint_white cycle of the latest blink.
  int     rec_start[$];
  coord_t rec_x[$];
  coord_t rec_y[$];
  coord_t last_scan_x;
  coord_t last_scan_y;
  bit     scan_seen = 1'b0;

  tb_clock_gen clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  cursor_display_top cursor_display_top_i (
    .clk        (clk),
    .rst        (rst),
    .step_left  (step_left),
    .step_right (step_right),
    .step_up    (step_up),
    .step_down  (step_down),
    .blink      (blink),
    .scan_x     (scan_x),
    .scan_y     (scan_y),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y),
    .scan_pixel (scan_pixel),
    .blink_done (blink_done)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic coord_t wrap_step(input coord_t pos, input logic dec, input logic inc);
    int v;
    v = int'(pos) + int'(inc) - int'(dec) + int'(FRAME_DIM);
    return coord_t'(v % int'(FRAME_DIM));
  endfunction

  // memory content at (x, y) during cycle c, known only once a blink wrote it.
  function automatic pixel_t expected_pixel(input coord_t x, input coord_t y, input int c,
                                            output bit known);
    pixel_t value;
    value = PIXEL_BLACK;
    known = 1'b0;
    for (int i = 0; i < rec_start.size(); i++) begin
      if (rec_x[i] == x && rec_y[i] == y) begin
        if (rec_start[i] < c) begin
          value = PIXEL_WHITE;
          known = 1'b1;
        end
        if (rec_start[i] + BLACK_OFFSET < c) begin
          value = PIXEL_BLACK;
        end
      end
    end
    return value;
  endfunction

  task automatic check_coord(input string name, input coord_t got, input coord_t exp);
    if (got !== exp) begin
      coord_errors++;
      $display("error: %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      pixel_errors++;
      $display("error: %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      flag_errors++;
      $display("error: %s got 0x%h expected 0x%h at cycle %0d", name, got, exp, cyc);
    end
  endtask

  task automatic finish_run();
    int total;
    total = coord_errors + pixel_errors + flag_errors + other_errors;
    $display("errors: coord %0d, pixel %0d, flag %0d, other %0d",
             coord_errors, pixel_errors, flag_errors, other_errors);
    if (total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  // outputs are compared at the falling edge, where they are stable.
  always @(negedge clk) begin : compare_proc
    pixel_t exp_pix;
    bit     known;
    bit     idle;
    logic   exp_done;
    if (rst !== 1'b0) begin
      model_x = CURSOR_HOME_X;
      model_y = CURSOR_HOME_Y;
      scan_seen = 1'b0;
    end else begin
      check_coord("cursor_x", cursor_x, model_x);
      check_coord("cursor_y", cursor_y, model_y);
      exp_done = (cur_start >= 0) && (cyc == cur_start + DONE_OFFSET);
      check_flag("blink_done", blink_done, exp_done);
      if (scan_seen) begin
        exp_pix = expected_pixel(last_scan_x, last_scan_y, cyc - 1, known);
        if (known) begin
          check_pixel("scan_pixel", scan_pixel, exp_pix);
          if (exp_pix == PIXEL_WHITE) begin
            white_checks++;
          end else begin
            black_checks++;
          end
        end
      end
      last_scan_x = scan_x;
      last_scan_y = scan_y;
      scan_seen = 1'b1;
      idle = (cur_start < 0) || (cyc > cur_start + DONE_OFFSET);
      if (idle && blink) begin
        rec_start.push_back(cyc + 1); // paints the position of this idle cycle.
        rec_x.push_back(model_x);
        rec_y.push_back(model_y);
        cur_start = cyc + 1;
      end
      model_x = wrap_step(model_x, step_left, step_right);
      model_y = wrap_step(model_y, step_up, step_down);
    end
  end

  task automatic drive_steps(input logic [3:0] dirs);
    @(posedge clk);
    {step_left, step_right, step_up, step_down} <= dirs;
  endtask

  task automatic set_scan(input coord_t x, input coord_t y);
    @(posedge clk);
    scan_x <= x;
    scan_y <= y;
  endtask

  task automatic wait_done();
    do @(negedge clk); while (blink_done !== 1'b1);
    if (last_done >= 0 && cyc - last_done != BLINK_PERIOD) begin
      other_errors++;
      $display("blink_done pulses came %0d cycles apart instead of %0d",
               cyc - last_done, BLINK_PERIOD);
    end
    last_done = cyc;
  endtask

  initial begin : timeout_proc
    wait (cyc >= TIMEOUT_CYCLES);
    other_errors++;
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run();
  end

  initial begin : stimulus_proc
    logic [31:0] r;
    logic [3:0]  dirs;
    coord_t      p_x;
    coord_t      p_y;
    coord_t      q_x;
    coord_t      q_y;
    {step_left, step_right, step_up, step_down} = STEP_NONE;
    blink = 1'b0;
    scan_x = '0;
    scan_y = '0;

    wait (!rst);
    @(negedge clk);
    check_coord("cursor_x", cursor_x, CURSOR_HOME_X);
    check_coord("cursor_y", cursor_y, CURSOR_HOME_Y);
    check_flag("blink_done", blink_done, 1'b0);
    repeat (4) @(posedge clk); // blink stays low, done must stay low.

    // walk across every frame edge and back.
    repeat (EDGE_STEPS) drive_steps(STEP_LEFT);
    repeat (EDGE_STEPS) drive_steps(STEP_RIGHT);
    repeat (EDGE_STEPS) drive_steps(STEP_UP);
    repeat (EDGE_STEPS) drive_steps(STEP_DOWN);
    for (int i = 0; i < RANDOM_STEPS; i++) begin
      r = $random(seed);
      dirs = r[3:0]; // opposite pairs come up too.
      if (dirs == STEP_NONE) begin
        dirs = STEP_RIGHT;
      end
      drive_steps(dirs);
    end
    drive_steps(STEP_NONE);

    // three blinks at one position, read back all along.
    @(posedge clk);
    p_x = model_x;
    p_y = model_y;
    scan_x <= p_x;
    scan_y <= p_y;
    blink <= 1'b1;
    last_done = -1;
    repeat (3) wait_done();
    @(posedge clk);
    blink <= 1'b0;

    // one blink one column to the right.
    drive_steps(STEP_RIGHT);
    drive_steps(STEP_NONE);
    @(posedge clk);
    q_x = model_x;
    q_y = model_y;
    scan_x <= q_x;
    scan_y <= q_y;
    blink <= 1'b1;
    last_done = -1;
    wait_done();
    @(posedge clk);
    blink <= 1'b0;

    // back to p, then move to q while that blink runs.
    drive_steps(STEP_LEFT);
    drive_steps(STEP_NONE);
    @(posedge clk);
    blink <= 1'b1;
    last_done = -1;
    repeat (4) @(posedge clk);
    drive_steps(STEP_RIGHT);
    drive_steps(STEP_NONE);
    wait_done(); // paints p, q must stay black.
    wait_done(); // paints q.
    @(posedge clk);
    blink <= 1'b0;
    set_scan(p_x, p_y);
    repeat (4) @(posedge clk);

    if (white_checks == 0 || black_checks == 0) begin
      other_errors++;
      $display("no white or no black pixel read was checked");
    end
    finish_run();
  end

endmodule

/* filelist.f */
hw/cursor_pkg.sv
hw/pixel_write_if.sv
hw/cursor_move.sv
hw/blink_timer.sv
hw/cursor_blink_ctrl.sv
hw/frame_buffer.sv
hw/cursor_display_top.sv
sim/tb_clock_gen.sv
sim/cursor_display_tb.sv

/* Bender.yml */
package:
  name: cursor_display

sources:
  - files:
      - hw/cursor_pkg.sv
      - hw/pixel_write_if.sv
      - hw/cursor_move.sv
      - hw/blink_timer.sv
      - hw/cursor_blink_ctrl.sv
      - hw/frame_buffer.sv
      - hw/cursor_display_top.sv
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/cursor_display_tb.sv
